/* verilog.f */
verilog/issue_pkg.sv
verilog/enq_if.sv
verilog/dispatch_stage.sv
verilog/age_select.sv
verilog/issue_queue.sv
verilog/alu_ports.sv
verilog/issue_top.sv
sim/issue_tb.sv

/* Bender.yml */
package:
  name: issue_stage

sources:
  - verilog/issue_pkg.sv
  - verilog/enq_if.sv
  - verilog/dispatch_stage.sv
  - verilog/age_select.sv
  - verilog/issue_queue.sv
  - verilog/alu_ports.sv
  - verilog/issue_top.sv
  - target: simulation
    files:
      - sim/issue_tb.sv

/* sim/issue_tb.sv */
`timescale 1ns/100ps

module issue_tb;

    localparam int clk_period = 40;
    // indep, chain, alu_ops, full_queue, one_stall
    localparam int total_ops = 40 + 80 + 60 + 8 + 80;
    localparam int mode_indep = 0;
    localparam int mode_chain = 1;
    localparam int mode_mixed = 2;

    logic                 clk;
    logic                 rst;
    logic [1:0]           i_disp_valid;
    issue_pkg::micro_op_t i_disp_uop [2];
    logic                 o_disp_ready;
    logic [1:0]           i_port_stall;
    logic [1:0]           o_wb_valid;
    issue_pkg::preg_t     o_wb_prd [2];
    issue_pkg::data_t     o_wb_data [2];

    logic [31:0]      rng;
    int               errors;
    int               checks;
    int               pending;
    int               wb_seen;
    int               accepted;
    int               last_dst;
    string            test_name;
    issue_pkg::seq_t  seq;
    // rename model mapping 8 architectural onto 32 physical registers
    int               arch_map [8];
    int               free_list [$];
    logic [31:0]      on_free;
    // value model and per-prd bookkeeping
    issue_pkg::data_t exp_val [32];
    logic [31:0]      in_flight;
    int               readers [32];
    int               src_a [32];
    int               src_b [32];
    // stall driven one negedge before the current one
    logic [1:0]       stall_old;

    issue_top dut (
        .clk          (clk),
        .rst          (rst),
        .i_disp_valid (i_disp_valid),
        .i_disp_uop   (i_disp_uop),
        .o_disp_ready (o_disp_ready),
        .i_port_stall (i_port_stall),
        .o_wb_valid   (o_wb_valid),
        .o_wb_prd     (o_wb_prd),
        .o_wb_data    (o_wb_data)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_rand(input int range);
        rng = xorshift(rng);
        return int'(rng % range);
    endfunction

    // worked in 32 bits and cut back to the 16-bit result
    function automatic issue_pkg::data_t expected_result(input issue_pkg::alu_op_e op,
                                                         input issue_pkg::data_t   a,
                                                         input issue_pkg::data_t   b);
        int wide;
        case (op)
            issue_pkg::add:    wide = int'(a) + int'(b);
            issue_pkg::sub:    wide = int'(a) - int'(b);
            issue_pkg::and_op: wide = int'(a & b);
            issue_pkg::xor_op: wide = int'(a ^ b);
            issue_pkg::shl:    wide = int'(a) * (1 << b[3:0]);
            default:           wide = 0;
        endcase
        return issue_pkg::data_t'(wide);
    endfunction

    function automatic logic is_mapped(input int p);
        for (int a = 0; a < 8; a++) begin
            if (arch_map[a] == p) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // a prd goes back once written, unmapped and no longer read
    task automatic try_free(input int p);
        if (!in_flight[p] && (readers[p] == 0) && !on_free[p] && !is_mapped(p)) begin
            free_list.push_back(p);
            on_free[p] = 1'b1;
        end
    endtask

    task automatic issue_one(input int p, input int mode);
        issue_pkg::micro_op_t u;
        int                   d;
        int                   s1;
        int                   s2;
        int                   old;
        u.op      = issue_pkg::alu_op_e'(next_rand(5));
        u.use_imm = logic'(next_rand(2));
        u.imm     = issue_pkg::data_t'(next_rand(65536));
        d         = (mode == mode_indep) ? 4 + next_rand(4) : next_rand(8);
        s1        = (mode == mode_indep) ? next_rand(4) : next_rand(8);
        s2        = (mode == mode_indep) ? next_rand(4) : next_rand(8);
        // port 1 consumes the port-0 result of the same cycle
        if ((mode == mode_chain) && ((p == 1) || (next_rand(4) != 0))) begin
            s1 = last_dst;
        end
        u.prs1 = issue_pkg::preg_t'(arch_map[s1]);
        u.prs2 = issue_pkg::preg_t'(arch_map[s2]);
        u.prd  = issue_pkg::preg_t'(free_list.pop_front());
        u.seq  = seq;
        seq    = seq + 1'b1;
        exp_val[u.prd] = expected_result(u.op, exp_val[u.prs1],
                                         u.use_imm ? u.imm : exp_val[u.prs2]);
        readers[u.prs1]++;
        src_a[u.prd] = u.prs1;
        src_b[u.prd] = u.use_imm ? -1 : int'(u.prs2);
        if (!u.use_imm) begin
            readers[u.prs2]++;
        end
        on_free[u.prd]   = 1'b0;
        in_flight[u.prd] = 1'b1;
        old         = arch_map[d];
        arch_map[d] = u.prd;
        try_free(old);
        pending++;
        last_dst        = d;
        i_disp_uop[p]   = u;
        i_disp_valid[p] = 1'b1;
    endtask

    // outputs have been stable since the rising edge
    task automatic check_outputs();
        int prd;
        for (int p = 0; p < 2; p++) begin
            if (o_wb_valid[p] && stall_old[p]) begin
                errors++;
                $display("%s: port %0d wrote back two cycles after a stall", test_name, p);
            end
            if (o_wb_valid[p]) begin
                wb_seen++;
                prd = o_wb_prd[p];
                if (!in_flight[prd]) begin
                    errors++;
                    $display("%s: writeback of prd %0d that was not pending", test_name, prd);
                end else begin
                    checks++;
                    if (o_wb_data[p] !== exp_val[prd]) begin
                        errors++;
                        $display("error %s: prd %0d expected %h actual %h",
                                 test_name, prd, exp_val[prd], o_wb_data[p]);
                    end
                    in_flight[prd] = 1'b0;
                    pending--;
                    readers[src_a[prd]]--;
                    try_free(src_a[prd]);
                    if (src_b[prd] >= 0) begin
                        readers[src_b[prd]]--;
                        try_free(src_b[prd]);
                    end
                    try_free(prd);
                end
            end
        end
        stall_old = i_port_stall;
    endtask

    task automatic drain();
        while (pending > 0) begin
            @(negedge clk);
            check_outputs();
            i_disp_valid = '0;
            i_port_stall = '0;
        end
    endtask

    // stall_mode 0 runs free, 1 stalls one port or none at random
    task automatic run_test(input string name, input int mode, input int n_ops,
                            input int stall_mode);
        int sent;
        test_name = name;
        sent      = 0;
        while (sent < n_ops) begin
            @(negedge clk);
            check_outputs();
            i_disp_valid = '0;
            i_port_stall = (stall_mode == 1) ? 2'(next_rand(3)) : 2'b00;
            if (o_disp_ready && (free_list.size() >= 2)) begin
                for (int p = 0; p < 2; p++) begin
                    if ((sent < n_ops) && (next_rand(4) != 0)) begin
                        issue_one(p, mode);
                        sent++;
                    end
                end
            end
        end
        drain();
    endtask

    task automatic full_queue_test();
        test_name = "full_queue";
        accepted  = 0;
        wb_seen   = 0;
        repeat (30) begin
            @(negedge clk);
            check_outputs();
            i_disp_valid = '0;
            i_port_stall = 2'b11;
            if (o_disp_ready && (free_list.size() >= 2)) begin
                issue_one(0, mode_mixed);
                issue_one(1, mode_mixed);
                accepted += 2;
            end
        end
        @(negedge clk);
        check_outputs();
        if (o_disp_ready || (accepted > 8) || (wb_seen != 0)) begin
            errors++;
            $display("full_queue: ready %0b after %0d accepted ops with %0d writebacks",
                     o_disp_ready, accepted, wb_seen);
        end
        drain();
    endtask

    initial begin
        $display("timeout after %0d cycles", total_ops * 40 + 200);
        #((total_ops * 40 + 200) * clk_period);
        $display("watchdog fired with %0d ops still pending", pending);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        i_disp_valid  = '0;
        i_disp_uop[0] = '0;
        i_disp_uop[1] = '0;
        i_port_stall  = '0;
        rng           = 32'hecc3;
        errors        = 0;
        checks        = 0;
        pending       = 0;
        last_dst      = 0;
        seq           = '0;
        stall_old     = '0;
        in_flight     = '0;
        on_free       = '0;
        test_name     = "reset";
        // register i holds i after reset
        for (int r = 0; r < 32; r++) begin
            exp_val[r] = issue_pkg::data_t'(r);
            readers[r] = 0;
            if (r < 8) begin
                arch_map[r] = r;
            end else begin
                free_list.push_back(r);
                on_free[r] = 1'b1;
            end
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;

        run_test("indep", mode_indep, 40, 0);
        run_test("chain", mode_chain, 80, 0);
        run_test("alu_ops", mode_mixed, 60, 0);
        full_queue_test();
        run_test("one_stall", mode_mixed, 80, 1);

        @(negedge clk);
        check_outputs();
        $display("errors: %0d, writebacks checked: %0d", errors, checks);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog/issue_top.sv */
`timescale 1ns/100ps

module issue_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [issue_pkg::port_num-1:0] i_disp_valid,
    input  issue_pkg::micro_op_t           i_disp_uop [issue_pkg::port_num],
    output logic                           o_disp_ready,
    input  logic [issue_pkg::port_num-1:0] i_port_stall,
    output logic [issue_pkg::port_num-1:0] o_wb_valid,
    output issue_pkg::preg_t               o_wb_prd [issue_pkg::port_num],
    output issue_pkg::data_t               o_wb_data [issue_pkg::port_num]
);

    enq_if enq ();

    // queue to ALU ports
    logic [issue_pkg::port_num-1:0] issue_vld;
    issue_pkg::issue_state_t        issue_state [issue_pkg::port_num];

    // back from the ALU ports
    logic [issue_pkg::port_num-1:0] fb_ok;
    issue_pkg::iq_idx_t             fb_idx [issue_pkg::port_num];
    logic [issue_pkg::port_num-1:0] wk_vec;
    issue_pkg::preg_t               wk_prd [issue_pkg::port_num];

    dispatch_stage u_dispatch (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_disp_valid),
        .i_uop    (i_disp_uop),
        .i_wk_vec (wk_vec),
        .i_wk_prd (wk_prd),
        .o_ready  (o_disp_ready),
        .enq      (enq.dispatch)
    );

    issue_queue u_queue (
        .clk           (clk),
        .rst           (rst),
        .i_port_stall  (i_port_stall),
        .i_wk_vec      (wk_vec),
        .i_wk_prd      (wk_prd),
        .i_fb_ok       (fb_ok),
        .i_fb_idx      (fb_idx),
        .o_issue_vld   (issue_vld),
        .o_issue_state (issue_state),
        .enq           (enq.queue)
    );

    alu_ports u_alu (
        .clk           (clk),
        .rst           (rst),
        .i_issue_vld   (issue_vld),
        .i_issue_state (issue_state),
        .o_wk_vec      (wk_vec),
        .o_wk_prd      (wk_prd),
        .o_fb_ok       (fb_ok),
        .o_fb_idx      (fb_idx),
        .o_wb_valid    (o_wb_valid),
        .o_wb_prd      (o_wb_prd),
        .o_wb_data     (o_wb_data)
    );

endmodule

/* verilog/alu_ports.sv */
`timescale 1ns/100ps

module alu_ports (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [issue_pkg::port_num-1:0] i_issue_vld,
    input  issue_pkg::issue_state_t        i_issue_state [issue_pkg::port_num],
    output logic [issue_pkg::port_num-1:0] o_wk_vec,
    output issue_pkg::preg_t               o_wk_prd [issue_pkg::port_num],
    output logic [issue_pkg::port_num-1:0] o_fb_ok,
    output issue_pkg::iq_idx_t             o_fb_idx [issue_pkg::port_num],
    output logic [issue_pkg::port_num-1:0] o_wb_valid,
    output issue_pkg::preg_t               o_wb_prd [issue_pkg::port_num],
    output issue_pkg::data_t               o_wb_data [issue_pkg::port_num]
);

    // physical register file with one write port per ALU
    issue_pkg::data_t rf [issue_pkg::preg_num];

    issue_pkg::data_t src1 [issue_pkg::port_num];
    issue_pkg::data_t src2 [issue_pkg::port_num];
    issue_pkg::data_t result [issue_pkg::port_num];

    // writeback stage
    logic [issue_pkg::port_num-1:0] ex_vld;
    issue_pkg::data_t               ex_data [issue_pkg::port_num];
    issue_pkg::preg_t               ex_prd [issue_pkg::port_num];
    issue_pkg::iq_idx_t             ex_idx [issue_pkg::port_num];

    function automatic issue_pkg::data_t alu_calc(
        issue_pkg::alu_op_e op,
        issue_pkg::data_t   a,
        issue_pkg::data_t   b
    );
        case (op)
            issue_pkg::add:    return a + b;
            issue_pkg::sub:    return a - b;
            issue_pkg::and_op: return a & b;
            issue_pkg::xor_op: return a ^ b;
            issue_pkg::shl:    return a << b[3:0];
            default:           return '0;
        endcase
    endfunction

    // operand read and execute in the cycle after issue
    always_comb begin
        for (int p = 0; p < issue_pkg::port_num; p++) begin
            src1[p] = rf[i_issue_state[p].uop.prs1];
            src2[p] = i_issue_state[p].uop.use_imm ? i_issue_state[p].uop.imm
                                                   : rf[i_issue_state[p].uop.prs2];
            result[p] = alu_calc(i_issue_state[p].uop.op, src1[p], src2[p]);
        end
    end

    // register i starts out holding i
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < issue_pkg::preg_num; r++) begin
                rf[r] <= issue_pkg::data_t'(r);
            end
        end else begin
            for (int p = 0; p < issue_pkg::port_num; p++) begin
                if (i_issue_vld[p]) begin
                    rf[i_issue_state[p].uop.prd] <= result[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_vld <= '0;
        end else begin
            ex_vld <= i_issue_vld;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < issue_pkg::port_num; p++) begin
            ex_data[p] <= result[p];
            ex_prd[p]  <= i_issue_state[p].uop.prd;
            ex_idx[p]  <= i_issue_state[p].idx;
        end
    end

    // writeback, wakeup and feedback all in the cycle after the write edge
    assign o_wb_valid = ex_vld;
    assign o_wb_prd   = ex_prd;
    assign o_wb_data  = ex_data;
    assign o_wk_vec   = ex_vld;
    assign o_wk_prd   = ex_prd;
    // every issue succeeds
    assign o_fb_ok    = ex_vld;
    assign o_fb_idx   = ex_idx;

endmodule

/* verilog/issue_queue.sv */
`timescale 1ns/100ps

module issue_queue (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [issue_pkg::port_num-1:0] i_port_stall,
    input  logic [issue_pkg::port_num-1:0] i_wk_vec,
    input  issue_pkg::preg_t               i_wk_prd [issue_pkg::port_num],
    input  logic [issue_pkg::port_num-1:0] i_fb_ok,
    input  issue_pkg::iq_idx_t             i_fb_idx [issue_pkg::port_num],
    output logic [issue_pkg::port_num-1:0] o_issue_vld,
    output issue_pkg::issue_state_t        o_issue_state [issue_pkg::port_num],
    enq_if.queue                           enq
);

    // entry storage
    logic [issue_pkg::iq_depth-1:0] ent_vld;
    logic [issue_pkg::iq_depth-1:0] ent_issued;
    logic [1:0]                     ent_rdy [issue_pkg::iq_depth];
    logic [1:0]                     nxt_rdy [issue_pkg::iq_depth];
    issue_pkg::micro_op_t           ent_uop [issue_pkg::iq_depth];

    // enqueue side
    logic [issue_pkg::port_num-1:0] free_fnd;
    issue_pkg::iq_idx_t             free_idx [issue_pkg::port_num];
    logic [issue_pkg::port_num-1:0] enq_fire;

    // select side
    logic [issue_pkg::iq_depth-1:0] entry_ready;
    issue_pkg::seq_t                ent_seq [issue_pkg::iq_depth];
    logic [issue_pkg::port_num-1:0] pick_vld;
    issue_pkg::iq_idx_t             pick_idx [issue_pkg::port_num];
    logic [issue_pkg::port_num-1:0] sel_vld;
    issue_pkg::iq_idx_t             sel_idx [issue_pkg::port_num];

    // two distinct free slots, lowest index first
    always_comb begin
        logic [issue_pkg::iq_depth-1:0] avail;
        avail = ~ent_vld;
        for (int p = 0; p < issue_pkg::port_num; p++) begin
            free_fnd[p] = 1'b0;
            free_idx[p] = '0;
            for (int i = issue_pkg::iq_depth - 1; i >= 0; i--) begin
                if (avail[i]) begin
                    free_fnd[p] = 1'b1;
                    free_idx[p] = issue_pkg::iq_idx_t'(i);
                end
            end
            if (free_fnd[p]) begin
                avail[free_idx[p]] = 1'b0;
            end
        end
    end

    assign enq.can_enq = &free_fnd;
    assign enq_fire    = enq.enq_req & {issue_pkg::port_num{enq.can_enq}};

    // wakeup against the broadcast prds
    always_comb begin
        for (int i = 0; i < issue_pkg::iq_depth; i++) begin
            nxt_rdy[i] = ent_rdy[i];
            for (int w = 0; w < issue_pkg::port_num; w++) begin
                if (i_wk_vec[w] && (ent_uop[i].prs1 == i_wk_prd[w])) begin
                    nxt_rdy[i][0] = 1'b1;
                end
                if (i_wk_vec[w] && (ent_uop[i].prs2 == i_wk_prd[w])) begin
                    nxt_rdy[i][1] = 1'b1;
                end
            end
            // stored readiness only so a wakeup selects one cycle later
            entry_ready[i] = ent_vld[i] && !ent_issued[i] && (&ent_rdy[i]);
            ent_seq[i]     = ent_uop[i].seq;
        end
    end

    age_select u_age_select (
        .i_ready (entry_ready),
        .i_seq   (ent_seq),
        .o_vld   (pick_vld),
        .o_idx   (pick_idx)
    );

    // map the two picks onto the ports that are not stalled
    always_comb begin
        sel_vld    = '0;
        sel_idx[0] = pick_idx[0];
        sel_idx[1] = pick_idx[1];
        case (i_port_stall)
            2'b00: begin
                sel_vld = pick_vld;
            end
            2'b01: begin
                // only port 1 free so the oldest goes there
                sel_vld[1] = pick_vld[0];
                sel_idx[1] = pick_idx[0];
            end
            2'b10: begin
                sel_vld[0] = pick_vld[0];
            end
            default: begin
                sel_vld = '0;
            end
        endcase
    end

    // valid and issued flags
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_vld     <= '0;
            ent_issued  <= '0;
            o_issue_vld <= '0;
        end else begin
            o_issue_vld <= sel_vld;
            for (int p = 0; p < issue_pkg::port_num; p++) begin
                if (i_fb_ok[p]) begin
                    ent_vld[i_fb_idx[p]] <= 1'b0;
                end
                if (sel_vld[p]) begin
                    ent_issued[sel_idx[p]] <= 1'b1;
                end
                if (enq_fire[p]) begin
                    ent_vld[free_idx[p]]    <= 1'b1;
                    ent_issued[free_idx[p]] <= 1'b0;
                end
            end
        end
    end

    // entry payload and the issue register
    always_ff @(posedge clk) begin
        for (int i = 0; i < issue_pkg::iq_depth; i++) begin
            ent_rdy[i] <= nxt_rdy[i];
        end
        for (int p = 0; p < issue_pkg::port_num; p++) begin
            if (enq_fire[p]) begin
                ent_uop[free_idx[p]] <= enq.uop[p];
                ent_rdy[free_idx[p]] <= enq.src_rdy[p];
            end
            if (sel_vld[p]) begin
                o_issue_state[p].uop <= ent_uop[sel_idx[p]];
                o_issue_state[p].idx <= sel_idx[p];
            end
        end
    end

endmodule

/* verilog/age_select.sv */
`timescale 1ns/100ps

module age_select (
    input  logic [issue_pkg::iq_depth-1:0] i_ready,
    input  issue_pkg::seq_t                i_seq [issue_pkg::iq_depth],
    output logic [issue_pkg::port_num-1:0] o_vld,
    output issue_pkg::iq_idx_t             o_idx [issue_pkg::port_num]
);

    // entries still open to each pick
    logic [issue_pkg::iq_depth-1:0] cand [issue_pkg::port_num];

    always_comb begin
        for (int p = 0; p < issue_pkg::port_num; p++) begin
            if (p == 0) begin
                cand[p] = i_ready;
            end else begin
                // drop what the earlier pick took
                cand[p] = cand[p-1];
                if (o_vld[p-1]) begin
                    cand[p][o_idx[p-1]] = 1'b0;
                end
            end

            o_vld[p] = 1'b0;
            o_idx[p] = '0;
            // strictly older replaces, so ties stay with the lower index
            for (int i = 0; i < issue_pkg::iq_depth; i++) begin
                if (cand[p][i] &&
                    (!o_vld[p] || issue_pkg::seq_older(i_seq[i], i_seq[o_idx[p]]))) begin
                    o_vld[p] = 1'b1;
                    o_idx[p] = issue_pkg::iq_idx_t'(i);
                end
            end
        end
    end

endmodule

/* verilog/dispatch_stage.sv */
`timescale 1ns/100ps

module dispatch_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [issue_pkg::port_num-1:0] i_valid,
    input  issue_pkg::micro_op_t           i_uop [issue_pkg::port_num],
    input  logic [issue_pkg::port_num-1:0] i_wk_vec,
    input  issue_pkg::preg_t               i_wk_prd [issue_pkg::port_num],
    output logic                           o_ready,
    enq_if.dispatch                        enq
);

    // set while the producer of a register is in flight
    logic [issue_pkg::preg_num-1:0] busy;
    logic [issue_pkg::port_num-1:0] accept;

    assign o_ready     = enq.can_enq;
    assign enq.enq_req = i_valid;
    assign accept      = i_valid & {issue_pkg::port_num{enq.can_enq}};

    // source readiness for each port and operand
    always_comb begin
        issue_pkg::preg_t src;
        logic             rdy;
        for (int p = 0; p < issue_pkg::port_num; p++) begin
            enq.uop[p] = i_uop[p];
            for (int s = 0; s < 2; s++) begin
                src = (s == 0) ? i_uop[p].prs1 : i_uop[p].prs2;
                rdy = !busy[src];
                // writeback broadcast in this cycle
                for (int w = 0; w < issue_pkg::port_num; w++) begin
                    if (i_wk_vec[w] && (i_wk_prd[w] == src)) begin
                        rdy = 1'b1;
                    end
                end
                // producer sitting on port 0 right next to us
                if ((p == 1) && accept[0] && (i_uop[0].prd == src)) begin
                    rdy = 1'b0;
                end
                if ((s == 1) && i_uop[p].use_imm) begin
                    rdy = 1'b1;
                end
                enq.src_rdy[p][s] = rdy;
            end
        end
    end

    // busy table
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            for (int w = 0; w < issue_pkg::port_num; w++) begin
                if (i_wk_vec[w]) begin
                    busy[i_wk_prd[w]] <= 1'b0;
                end
            end
            // a new producer wins over a clear of the same register
            for (int p = 0; p < issue_pkg::port_num; p++) begin
                if (accept[p]) begin
                    busy[i_uop[p].prd] <= 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/enq_if.sv */
`timescale 1ns/100ps

interface enq_if;

    // one lane per dispatch port
    logic [issue_pkg::port_num-1:0] enq_req;
    issue_pkg::micro_op_t           uop [issue_pkg::port_num];
    // bit 0 is prs1, bit 1 is prs2
    logic [1:0]                     src_rdy [issue_pkg::port_num];
    // at least two slots free
    logic                           can_enq;

    modport dispatch (
        output enq_req,
        output uop,
        output src_rdy,
        input  can_enq
    );

    modport queue (
        input  enq_req,
        input  uop,
        input  src_rdy,
        output can_enq
    );

endinterface

/* verilog/issue_pkg.sv */
package issue_pkg;

    // machine sizes
    localparam int iq_depth = 8;
    localparam int port_num = 2;
    localparam int preg_num = 32;

    typedef logic [4:0]  preg_t;
    typedef logic [15:0] data_t;
    // wrapping age tag
    typedef logic [5:0]  seq_t;
    typedef logic [2:0]  iq_idx_t;

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        xor_op,
        // src1 shifted left by the low four bits of src2
        shl
    } alu_op_e;

    typedef struct packed {
        alu_op_e op;
        preg_t   prd;
        preg_t   prs1;
        preg_t   prs2;
        // src2 taken from imm and never waits
        logic    use_imm;
        data_t   imm;
        seq_t    seq;
    } micro_op_t;

    // what an ALU port needs from the queue
    typedef struct packed {
        micro_op_t uop;
        iq_idx_t   idx;
    } issue_state_t;

    // a is older than b when (b - a) mod 64 is below 32
    // equal tags count as not older
    function automatic logic seq_older(seq_t a, seq_t b);
        seq_t diff;
        diff = b - a;
        return (diff != '0) && !diff[$bits(seq_t)-1];
    endfunction

endpackage
